// File: Makefile
# Verilator build and run of the vertex job unit testbench

VERILATOR  ?= verilator
TOP        ?= tb_vertex_job_control
FILELIST   ?= compile.f
BUILD_DIR  ?= obj_dir
VFLAGS     ?= --binary --timing --assert
LINT_FLAGS ?= --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

# a failing run ends in $fatal, which gives a nonzero exit status
run: build
	./$(BUILD_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

// File: compile.f
logic/graph_pkg.sv
logic/mem_pkg.sv
logic/job_fifo.sv
logic/read_sequencer.sv
logic/line_capture.sv
logic/vertex_assembler.sv
logic/vertex_job_control.sv
sim/memory_responder.sv
sim/tb_vertex_job_control.sv

// File: logic/graph_pkg.sv
// vertex and work descriptor types, shared by the vertex job unit and its testbench
package graph_pkg;

	// width of each per-vertex field
	parameter int vertex_bits = 32;

	// one vertex job as handed to the consumer
	typedef struct packed {
		logic [vertex_bits-1:0] id;
		logic [vertex_bits-1:0] inverse_out_degree;
		logic [vertex_bits-1:0] inverse_edges_idx;
		logic [vertex_bits-1:0] parent;
	} vertex_t;

	// work descriptor, sampled on start
	typedef struct packed {
		logic [31:0] num_vertices;
		logic [31:0] id_base;
		logic [31:0] out_degree_base;
		logic [31:0] edges_idx_base;
		logic [31:0] parent_base;
	} job_desc_t;

endpackage

// File: logic/job_fifo.sv
// fall-through queue with a typed payload, holds read commands or vertex jobs
`timescale 1ns/1ps

module job_fifo #(
	parameter type payload_t = logic [7:0],
	parameter int depth = 4,
	parameter int almost_full_level = depth
) (
	input  logic     clock,
	input  logic     rstn,
	input  logic     push,
	input  payload_t data_in,
	input  logic     pop,
	output payload_t data_out,
	output logic     empty,
	output logic     almost_full
);

	localparam int ptr_bits = (depth > 1) ? $clog2(depth) : 1;
	localparam int count_bits = $clog2(depth + 1);

	payload_t              mem [depth];
	logic [ptr_bits-1:0]   wr_ptr;
	logic [ptr_bits-1:0]   rd_ptr;
	logic [count_bits-1:0] count;

	// storage carries no reset
	always_ff @(posedge clock) begin
		if (push)
			mem[wr_ptr] <= data_in;
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push)
				wr_ptr <= (wr_ptr == ptr_bits'(depth - 1)) ? '0 : wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= (rd_ptr == ptr_bits'(depth - 1)) ? '0 : rd_ptr + 1'b1;
			if (push && !pop)
				count <= count + 1'b1;
			else if (pop && !push)
				count <= count - 1'b1;
		end
	end

	// head visible without a read cycle
	assign data_out    = mem[rd_ptr];
	assign empty       = (count == '0);
	assign almost_full = (count >= count_bits'(almost_full_level));

	a_no_overflow: assert property (@(posedge clock) disable iff (!rstn)
		push |-> (count != count_bits'(depth)));
	a_no_underflow: assert property (@(posedge clock) disable iff (!rstn)
		pop |-> !empty);

endmodule

// File: logic/line_capture.sv
// holds the returned out-degree, edges-idx and parent lines until the chunk is shifted out
`timescale 1ns/1ps

module line_capture (
	input  logic                 clock,
	input  logic                 rstn,
	input  logic                 return_valid,
	input  mem_pkg::read_return_t return_line,
	input  logic                 clear,
	output logic                 lines_ready,
	output mem_pkg::line_t       degree_line,
	output mem_pkg::line_t       edges_line,
	output mem_pkg::line_t       parent_line
);

	logic degree_seen;
	logic edges_seen;
	logic parent_seen;
	logic tag_seen;

	// arrival flags
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			degree_seen <= 1'b0;
			edges_seen  <= 1'b0;
			parent_seen <= 1'b0;
		end else if (clear) begin
			degree_seen <= 1'b0;
			edges_seen  <= 1'b0;
			parent_seen <= 1'b0;
		end else if (return_valid) begin
			case (return_line.array_sel)
				mem_pkg::array_out_degree: degree_seen <= 1'b1;
				mem_pkg::array_edges_idx:  edges_seen  <= 1'b1;
				mem_pkg::array_parent:     parent_seen <= 1'b1;
				default: ;
			endcase
		end
	end

	// line data, stored under its tag
	always_ff @(posedge clock) begin
		if (return_valid) begin
			case (return_line.array_sel)
				mem_pkg::array_out_degree: degree_line <= return_line.line;
				mem_pkg::array_edges_idx:  edges_line  <= return_line.line;
				mem_pkg::array_parent:     parent_line <= return_line.line;
				default: ;
			endcase
		end
	end

	assign lines_ready = degree_seen && edges_seen && parent_seen;

	always_comb begin
		case (return_line.array_sel)
			mem_pkg::array_out_degree: tag_seen = degree_seen;
			mem_pkg::array_edges_idx:  tag_seen = edges_seen;
			mem_pkg::array_parent:     tag_seen = parent_seen;
			default:                   tag_seen = 1'b1;
		endcase
	end

	// one return per array per chunk, valid tags only
	a_single_return: assert property (@(posedge clock) disable iff (!rstn)
		return_valid |-> !tag_seen);

endmodule

// File: logic/mem_pkg.sv
// memory line, array tag, read command and read return types for the memory side of the unit
package mem_pkg;

	parameter int addr_bits = 32;

	// one line carries this many vertex words
	parameter int line_vertices = 4;
	parameter int line_bytes = 16;

	// vertex 0 sits in the most significant word
	typedef logic [line_vertices*graph_pkg::vertex_bits-1:0] line_t;

	// vertices in one chunk, 1 up to line_vertices
	typedef logic [2:0] count_t;

	typedef enum logic [1:0] {
		array_out_degree = 2'd0,
		array_edges_idx  = 2'd1,
		array_parent     = 2'd2
	} array_sel_e;

	typedef struct packed {
		logic [addr_bits-1:0] address;
		array_sel_e           array_sel;
		count_t               count;
	} read_command_t;

	// tag and data return together
	typedef struct packed {
		array_sel_e array_sel;
		line_t      line;
	} read_return_t;

endpackage

// File: logic/read_sequencer.sv
// splits a job into line-sized chunks and issues the three array reads of each chunk
`timescale 1ns/1ps

module read_sequencer (
	input  logic                  clock,
	input  logic                  rstn,
	input  logic                  start,
	input  graph_pkg::job_desc_t  job,
	input  logic                  command_empty,
	input  logic                  vertex_almost_full,
	input  logic                  chunk_done,
	output logic                  command_push,
	output mem_pkg::read_command_t command,
	output mem_pkg::count_t       chunk_count,
	output logic                  busy
);

	typedef enum logic [2:0] {
		idle,
		wait_room,
		issue_degree,
		issue_edges,
		issue_parent,
		wait_chunk
	} state_e;

	state_e                        state;
	graph_pkg::job_desc_t          job_q;
	logic [31:0]                   remaining;
	logic [mem_pkg::addr_bits-1:0] offset;
	mem_pkg::count_t               chunk_next;

	// full line unless this is the tail
	assign chunk_next = (remaining > 32'(mem_pkg::line_vertices)) ?
		mem_pkg::count_t'(mem_pkg::line_vertices) : mem_pkg::count_t'(remaining);

	//////////////////////////////
	// chunk FSM
	//////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			state       <= idle;
			remaining   <= '0;
			offset      <= '0;
			chunk_count <= '0;
		end else begin
			case (state)
				idle: begin
					if (start && job.num_vertices != '0) begin
						state     <= wait_room;
						remaining <= job.num_vertices;
						offset    <= '0;
					end
				end
				wait_room: begin
					// whole chunk must fit in the vertex queue
					if (command_empty && !vertex_almost_full) begin
						state       <= issue_degree;
						chunk_count <= chunk_next;
					end
				end
				issue_degree: state <= issue_edges;
				issue_edges:  state <= issue_parent;
				issue_parent: begin
					state     <= wait_chunk;
					remaining <= remaining - 32'(chunk_count);
					offset    <= offset + mem_pkg::line_bytes;
				end
				wait_chunk: begin
					if (chunk_done)
						state <= (remaining == '0) ? idle : wait_room;
				end
				default: state <= idle;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (state == idle && start)
			job_q <= job;
	end

	//////////////////////////////
	// command build
	//////////////////////////////

	always_comb begin
		command.count     = chunk_count;
		command.array_sel = mem_pkg::array_out_degree;
		command.address   = job_q.out_degree_base + offset;
		case (state)
			issue_edges: begin
				command.array_sel = mem_pkg::array_edges_idx;
				command.address   = job_q.edges_idx_base + offset;
			end
			issue_parent: begin
				command.array_sel = mem_pkg::array_parent;
				command.address   = job_q.parent_base + offset;
			end
			default: ;
		endcase
	end

	assign command_push = (state == issue_degree) || (state == issue_edges) ||
		(state == issue_parent);
	assign busy = (state != idle);

	// assembler only finishes a chunk we issued
	a_done_in_wait: assert property (@(posedge clock) disable iff (!rstn)
		chunk_done |-> (state == wait_chunk));

endmodule

// File: logic/vertex_assembler.sv
// shifts the three captured lines out as one vertex job per cycle and closes the chunk
`timescale 1ns/1ps

module vertex_assembler (
	input  logic              clock,
	input  logic              rstn,
	input  logic              busy,
	input  logic              lines_ready,
	input  mem_pkg::line_t    degree_line,
	input  mem_pkg::line_t    edges_line,
	input  mem_pkg::line_t    parent_line,
	input  mem_pkg::count_t   chunk_count,
	input  logic [31:0]       id_base,
	output logic              vertex_push,
	output graph_pkg::vertex_t vertex,
	output logic              chunk_done
);

	localparam int top_bit = $bits(mem_pkg::line_t) - 1;

	logic                              shifting;
	mem_pkg::count_t                   left;
	mem_pkg::line_t                    degree_shift;
	mem_pkg::line_t                    edges_shift;
	mem_pkg::line_t                    parent_shift;
	logic [graph_pkg::vertex_bits-1:0] next_id;

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			shifting   <= 1'b0;
			left       <= '0;
			chunk_done <= 1'b0;
			next_id    <= '0;
		end else begin
			chunk_done <= 1'b0;
			// lines_ready still high during chunk_done, so skip that cycle
			if (!shifting && !chunk_done && lines_ready) begin
				shifting <= 1'b1;
				left     <= chunk_count;
			end else if (shifting) begin
				left <= left - mem_pkg::count_t'(1);
				if (left == mem_pkg::count_t'(1)) begin
					shifting   <= 1'b0;
					chunk_done <= 1'b1;
				end
			end
			// id restarts from the descriptor base between jobs
			if (!busy)
				next_id <= id_base;
			else if (shifting)
				next_id <= next_id + 32'd1;
		end
	end

	always_ff @(posedge clock) begin
		if (!shifting && !chunk_done && lines_ready) begin
			degree_shift <= degree_line;
			edges_shift  <= edges_line;
			parent_shift <= parent_line;
		end else if (shifting) begin
			degree_shift <= degree_shift << graph_pkg::vertex_bits;
			edges_shift  <= edges_shift << graph_pkg::vertex_bits;
			parent_shift <= parent_shift << graph_pkg::vertex_bits;
		end
	end

	// top word of each line is the current vertex
	assign vertex.id                 = next_id;
	assign vertex.inverse_out_degree = degree_shift[top_bit -: graph_pkg::vertex_bits];
	assign vertex.inverse_edges_idx  = edges_shift[top_bit -: graph_pkg::vertex_bits];
	assign vertex.parent             = parent_shift[top_bit -: graph_pkg::vertex_bits];
	assign vertex_push               = shifting;

	a_count_range: assert property (@(posedge clock) disable iff (!rstn)
		shifting |-> (chunk_count != '0 &&
			chunk_count <= mem_pkg::count_t'(mem_pkg::line_vertices)));

endmodule

// File: logic/vertex_job_control.sv
// vertex job unit top level, connects command issue, line capture, assembly and both queues
`timescale 1ns/1ps

module vertex_job_control #(
	parameter int command_depth = 4,
	parameter int vertex_depth = 16
) (
	input  logic                   clock,
	input  logic                   rstn,
	input  logic                   start,
	input  graph_pkg::job_desc_t   job,
	output logic                   busy,
	output logic                   read_command_request,
	output mem_pkg::read_command_t read_command,
	input  logic                   read_command_grant,
	input  logic                   read_return_valid,
	input  mem_pkg::read_return_t  read_return,
	output logic                   vertex_valid,
	output graph_pkg::vertex_t     vertex,
	input  logic                   vertex_request
);

	logic                   command_push;
	mem_pkg::read_command_t command;
	logic                   command_empty;
	mem_pkg::count_t        chunk_count;
	logic                   chunk_done;
	logic                   lines_ready;
	mem_pkg::line_t         degree_line;
	mem_pkg::line_t         edges_line;
	mem_pkg::line_t         parent_line;
	logic                   vertex_push;
	graph_pkg::vertex_t     assembled;
	logic                   vertex_empty;
	logic                   vertex_almost_full;

	assign read_command_request = !command_empty;
	assign vertex_valid         = !vertex_empty;

	read_sequencer u_sequencer (
		.clock             (clock),
		.rstn              (rstn),
		.start             (start),
		.job               (job),
		.command_empty     (command_empty),
		.vertex_almost_full(vertex_almost_full),
		.chunk_done        (chunk_done),
		.command_push      (command_push),
		.command           (command),
		.chunk_count       (chunk_count),
		.busy              (busy)
	);

	// command queue, popped on request and grant
	job_fifo #(
		.payload_t        (mem_pkg::read_command_t),
		.depth            (command_depth),
		.almost_full_level(command_depth)
	) u_command_fifo (
		.clock      (clock),
		.rstn       (rstn),
		.push       (command_push),
		.data_in    (command),
		.pop        (read_command_request && read_command_grant),
		.data_out   (read_command),
		.empty      (command_empty),
		.almost_full()
	);

	line_capture u_capture (
		.clock       (clock),
		.rstn        (rstn),
		.return_valid(read_return_valid),
		.return_line (read_return),
		.clear       (chunk_done),
		.lines_ready (lines_ready),
		.degree_line (degree_line),
		.edges_line  (edges_line),
		.parent_line (parent_line)
	);

	vertex_assembler u_assembler (
		.clock      (clock),
		.rstn       (rstn),
		.busy       (busy),
		.lines_ready(lines_ready),
		.degree_line(degree_line),
		.edges_line (edges_line),
		.parent_line(parent_line),
		.chunk_count(chunk_count),
		.id_base    (job.id_base),
		.vertex_push(vertex_push),
		.vertex     (assembled),
		.chunk_done (chunk_done)
	);

	// leaves room for one full chunk
	job_fifo #(
		.payload_t        (graph_pkg::vertex_t),
		.depth            (vertex_depth),
		.almost_full_level(vertex_depth - mem_pkg::line_vertices)
	) u_vertex_fifo (
		.clock      (clock),
		.rstn       (rstn),
		.push       (vertex_push),
		.data_in    (assembled),
		.pop        (vertex_request && vertex_valid),
		.data_out   (vertex),
		.empty      (vertex_empty),
		.almost_full(vertex_almost_full)
	);

endmodule

// File: sim/memory_responder.sv
// testbench memory model, grants read commands at random and returns their lines after random delays
`timescale 1ns/1ps

module memory_responder (
	input  logic                   clock,
	input  logic                   rstn,
	input  logic                   read_command_request,
	input  mem_pkg::read_command_t read_command,
	output logic                   read_command_grant,
	output logic                   read_return_valid,
	output mem_pkg::read_return_t  read_return
);

	mem_pkg::read_command_t pending [$];
	int unsigned            due [$];
	int unsigned            cycle;

	// word at byte address a holds a ^ (0x1000_0000 * (tag + 1))
	function automatic mem_pkg::line_t line_at(input mem_pkg::read_command_t command);
		mem_pkg::line_t line;
		logic [31:0]    tag_constant;
		int             slot;
		tag_constant = 32'h1000_0000 * (32'(command.array_sel) + 32'd1);
		for (int i = 0; i < mem_pkg::line_vertices; i++) begin
			slot = mem_pkg::line_vertices - 1 - i;
			line[slot*graph_pkg::vertex_bits +: graph_pkg::vertex_bits] =
				(command.address + 32'(4 * i)) ^ tag_constant;
		end
		return line;
	endfunction

	initial begin
		int pick;
		read_command_grant = 1'b0;
		read_return_valid  = 1'b0;
		read_return        = '0;
		cycle              = 0;
		forever begin
			@(posedge clock);
			if (rstn && read_command_request && read_command_grant) begin
				pending.push_back(read_command);
				due.push_back(cycle + 1 + $urandom_range(0, 8));
			end
			cycle++;
			#1;
			// first entry whose delay ran out, so later grants can overtake
			pick = -1;
			foreach (due[i])
				if (pick < 0 && due[i] <= cycle)
					pick = i;
			read_return_valid = 1'b0;
			if (pick >= 0) begin
				read_return_valid     = 1'b1;
				read_return.array_sel = pending[pick].array_sel;
				read_return.line      = line_at(pending[pick]);
				pending.delete(pick);
				due.delete(pick);
			end
			read_command_grant = rstn && ($urandom_range(0, 2) != 0);
		end
	end

endmodule

// File: sim/tb_vertex_job_control.sv
// testbench for the vertex job unit, runs several jobs and checks commands and vertices against a model
`timescale 1ns/1ps

module tb_vertex_job_control;

	localparam int timeout_cycles = 3000;

	logic                   clock;
	logic                   rstn;
	logic                   start;
	graph_pkg::job_desc_t   job;
	logic                   busy;
	logic                   read_command_request;
	mem_pkg::read_command_t read_command;
	logic                   read_command_grant;
	logic                   read_return_valid;
	mem_pkg::read_return_t  read_return;
	logic                   vertex_valid;
	graph_pkg::vertex_t     vertex;
	logic                   vertex_request;
	logic                   consume;
	int                     pop_chance;
	int                     popped;

	mem_pkg::read_command_t expected_commands [$];
	graph_pkg::vertex_t     expected_vertices [$];

	vertex_job_control #(
		.command_depth(4),
		.vertex_depth (16)
	) DUT (
		.clock               (clock),
		.rstn                (rstn),
		.start               (start),
		.job                 (job),
		.busy                (busy),
		.read_command_request(read_command_request),
		.read_command        (read_command),
		.read_command_grant  (read_command_grant),
		.read_return_valid   (read_return_valid),
		.read_return         (read_return),
		.vertex_valid        (vertex_valid),
		.vertex              (vertex),
		.vertex_request      (vertex_request)
	);

	memory_responder u_memory (
		.clock               (clock),
		.rstn                (rstn),
		.read_command_request(read_command_request),
		.read_command        (read_command),
		.read_command_grant  (read_command_grant),
		.read_return_valid   (read_return_valid),
		.read_return         (read_return)
	);

	initial begin
		clock = 1'b0;
		forever #20 clock = ~clock;
	end

	task automatic stop_run(input string why);
		$display("%s", why);
		$display("CHECKS FAILED");
		$fatal(1, "simulation stopped at %0t", $time);
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] expected);
		if (got !== expected)
			stop_run($sformatf("** Error at %0t: %s is %h, expected %h", $time, name, got,
				expected));
	endtask

	// memory content rule
	function automatic logic [31:0] memory_word(input logic [31:0] address,
			input mem_pkg::array_sel_e sel);
		return address ^ (32'h1000_0000 * (32'(sel) + 32'd1));
	endfunction

	function automatic graph_pkg::job_desc_t make_job(input logic [31:0] num,
			input logic [31:0] id_base, input logic [31:0] degree_base,
			input logic [31:0] edges_base, input logic [31:0] parent_base);
		graph_pkg::job_desc_t desc;
		desc.num_vertices    = num;
		desc.id_base         = id_base;
		desc.out_degree_base = degree_base;
		desc.edges_idx_base  = edges_base;
		desc.parent_base     = parent_base;
		return desc;
	endfunction

	//////////////////////////////
	// reference model
	//////////////////////////////

	task automatic predict(input graph_pkg::job_desc_t desc);
		mem_pkg::read_command_t command;
		graph_pkg::vertex_t     expected;
		int unsigned            last;
		logic [31:0]            offset;
		last = (desc.num_vertices - 1) / mem_pkg::line_vertices;
		for (int unsigned c = 0; c <= last; c++) begin
			offset = c * mem_pkg::line_bytes;
			// tail chunk only carries the remainder
			command.count = (c == last) ?
				mem_pkg::count_t'(desc.num_vertices - c * mem_pkg::line_vertices) :
				mem_pkg::count_t'(mem_pkg::line_vertices);
			command.array_sel = mem_pkg::array_out_degree;
			command.address   = desc.out_degree_base + offset;
			expected_commands.push_back(command);
			command.array_sel = mem_pkg::array_edges_idx;
			command.address   = desc.edges_idx_base + offset;
			expected_commands.push_back(command);
			command.array_sel = mem_pkg::array_parent;
			command.address   = desc.parent_base + offset;
			expected_commands.push_back(command);
		end
		for (int unsigned i = 0; i < desc.num_vertices; i++) begin
			expected.id                 = desc.id_base + i;
			expected.inverse_out_degree = memory_word(desc.out_degree_base + 4 * i,
				mem_pkg::array_out_degree);
			expected.inverse_edges_idx  = memory_word(desc.edges_idx_base + 4 * i,
				mem_pkg::array_edges_idx);
			expected.parent             = memory_word(desc.parent_base + 4 * i,
				mem_pkg::array_parent);
			expected_vertices.push_back(expected);
		end
	endtask

	// granted commands, in issue order
	initial begin
		mem_pkg::read_command_t want;
		forever begin
			@(posedge clock);
			if (rstn && read_command_request && read_command_grant) begin
				if (expected_commands.size() == 0) begin
					stop_run("a read command was granted but none was expected");
				end else begin
					want = expected_commands.pop_front();
					check_value("read_command.address", read_command.address, want.address);
					check_value("read_command.array_sel", 32'(read_command.array_sel),
						32'(want.array_sel));
					check_value("read_command.count", 32'(read_command.count),
						32'(want.count));
				end
			end
		end
	end

	// consumer with random request gaps
	initial begin
		graph_pkg::vertex_t want;
		forever begin
			@(posedge clock);
			if (rstn && vertex_valid && vertex_request) begin
				if (expected_vertices.size() == 0) begin
					stop_run("a vertex was popped but none was expected");
				end else begin
					want = expected_vertices.pop_front();
					check_value("vertex.id", vertex.id, want.id);
					check_value("vertex.inverse_out_degree", vertex.inverse_out_degree,
						want.inverse_out_degree);
					check_value("vertex.inverse_edges_idx", vertex.inverse_edges_idx,
						want.inverse_edges_idx);
					check_value("vertex.parent", vertex.parent, want.parent);
					popped++;
				end
			end
			#1;
			vertex_request = consume && ($urandom_range(0, 99) < pop_chance);
		end
	end

	//////////////////////////////
	// job runner
	//////////////////////////////

	task automatic run_job(input graph_pkg::job_desc_t desc, input int chance);
		int waited;
		popped     = 0;
		pop_chance = chance;
		predict(desc);
		@(posedge clock);
		#1;
		job   = desc;
		start = 1'b1;
		@(posedge clock);
		#1;
		start  = 1'b0;
		waited = 0;
		while (popped < int'(desc.num_vertices)) begin
			if (waited == timeout_cycles)
				stop_run($sformatf("timeout, only %0d of %0d vertices arrived", popped,
					desc.num_vertices));
			@(posedge clock);
			waited++;
		end
		waited = 0;
		while (busy) begin
			if (waited == timeout_cycles)
				stop_run("timeout, busy stayed high after the last vertex");
			@(posedge clock);
			waited++;
		end
		// nothing left behind once the job is over
		#1;
		check_value("vertex_valid", 32'(vertex_valid), 32'd0);
		check_value("read_command_request", 32'(read_command_request), 32'd0);
	endtask

	initial begin
		void'($urandom(32'h016fddd2));
		rstn           = 1'b0;
		start          = 1'b0;
		job            = '0;
		vertex_request = 1'b0;
		consume        = 1'b0;
		pop_chance     = 100;
		popped         = 0;
		repeat (5) @(posedge clock);
		#1;
		rstn = 1'b1;
		check_value("read_command_request", 32'(read_command_request), 32'd0);
		check_value("vertex_valid", 32'(vertex_valid), 32'd0);
		check_value("busy", 32'(busy), 32'd0);
		consume = 1'b1;
		run_job(make_job(13, 32'd100, 32'h0000_1000, 32'h0000_2000, 32'h0000_3000), 70);
		run_job(make_job(8, 32'd5000, 32'h0004_0000, 32'h0005_0010, 32'h0006_0020), 100);
		run_job(make_job(3, 32'd7, 32'h0000_0040, 32'h0000_0080, 32'h0000_00c0), 50);
		// slow consumer backs up the vertex queue
		run_job(make_job($urandom_range(17, 45), $urandom, $urandom & 32'hffff_fffc,
			$urandom & 32'hffff_fffc, $urandom & 32'hffff_fffc), 20);
		run_job(make_job($urandom_range(1, 30), $urandom, $urandom & 32'hffff_fffc,
			$urandom & 32'hffff_fffc, $urandom & 32'hffff_fffc), 60);
		$display("ALL CHECKS PASSED");
		$finish;
	end

endmodule
